// File: hw/dcache_pkg.sv
// ======================================================================
// shared widths and types for the two-way data cache
// addresses are word addresses, lines hold four 32-bit words
// word 0 of a line sits in the low 32 bits
// ======================================================================

package dcache_pkg;

    // cpu side address and data
    parameter int ADDR_W = 30;          // word address width
    parameter int WORD_W = 32;          // data word width

    // line geometry
    parameter int WORDS_PER_LINE = 4;
    parameter int OFFSET_W = 2;         // word-in-line bits
    parameter int LINE_W = WORDS_PER_LINE * WORD_W;

    // payload types
    typedef logic [WORD_W-1:0] word_t;
    typedef logic [LINE_W-1:0] line_t;

    // miss handling FSM of the controller
    // IDLE    waits for a cpu request
    // LOOKUP  compares both tags, answers hits
    // EVICT   writes a dirty victim line out
    // FETCH   issues the line read
    // REFILL  waits for the returned line
    typedef enum logic [2:0] {
        IDLE   = 3'd0,
        LOOKUP = 3'd1,
        EVICT  = 3'd2,
        FETCH  = 3'd3,
        REFILL = 3'd4
    } ctrl_state_t;

endpackage

// File: hw/dcache_way.sv
// ======================================================================
// one way of the cache: valid, dirty, tag and line per set
// read side is combinational from index, writes land at the clock edge
// a write always marks the set valid
// ======================================================================

`timescale 1ns/10ps

module dcache_way #(
    parameter int INDEX_W = 8,
    localparam int TAG_W = dcache_pkg::ADDR_W - INDEX_W - dcache_pkg::OFFSET_W
) (
    input  logic                 clk,
    input  logic                 reset,
    // lookup side
    input  logic [INDEX_W-1:0]   index,        // set under access
    input  logic [TAG_W-1:0]     lookup_tag,   // tag of the cpu request
    output logic                 hit,
    output logic                 valid,
    output logic                 dirty,
    output logic [TAG_W-1:0]     stored_tag,
    output dcache_pkg::line_t    stored_line,
    // write side
    input  logic                 wr_en,
    input  logic [TAG_W-1:0]     wr_tag,
    input  dcache_pkg::line_t    wr_line,
    input  logic                 wr_dirty
);
    import dcache_pkg::*;

    localparam int SETS = 2 ** INDEX_W;

    logic [SETS-1:0]  valid_q;                 // one bit per set
    logic [SETS-1:0]  dirty_q;
    logic [TAG_W-1:0] tag_mem [SETS];
    line_t            line_mem [SETS];

    // addressed set, read out combinationally
    assign valid       = valid_q[index];
    assign dirty       = dirty_q[index];
    assign stored_tag  = tag_mem[index];
    assign stored_line = line_mem[index];

    assign hit = valid && (stored_tag == lookup_tag);

    // state bits, cleared by reset
    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (wr_en) begin
            valid_q[index] <= 1'b1;
            dirty_q[index] <= wr_dirty;
        end
    end

    // tag and data arrays
    always_ff @(posedge clk) begin
        if (wr_en) begin
            tag_mem[index]  <= wr_tag;
            line_mem[index] <= wr_line;
        end
    end

endmodule

// File: hw/dcache_ctrl.sv
// ======================================================================
// cache controller: request latch, hit/victim logic, LRU, miss FSM
// one cpu request in flight, req_ready only in IDLE
// hits answer in LOOKUP, misses answer with the memory response
// ======================================================================

`timescale 1ns/10ps

module dcache_ctrl #(
    parameter int INDEX_W = 8,
    localparam int TAG_W = dcache_pkg::ADDR_W - INDEX_W - dcache_pkg::OFFSET_W
) (
    input  logic                 clk,
    input  logic                 reset,
    // cpu request
    input  logic                 req_valid,
    input  logic                 req_write,
    input  logic [dcache_pkg::ADDR_W-1:0] req_addr,
    input  dcache_pkg::word_t    req_wdata,
    output logic                 req_ready,
    // cpu response
    output logic                 resp_valid,
    output dcache_pkg::word_t    resp_rdata,
    // memory request
    output logic                 mem_req_valid,
    output logic                 mem_req_write,
    output logic [dcache_pkg::ADDR_W-dcache_pkg::OFFSET_W-1:0] mem_req_addr,
    output dcache_pkg::line_t    mem_req_wdata,
    input  logic                 mem_req_ready,
    // memory response
    input  logic                 mem_resp_valid,
    input  dcache_pkg::line_t    mem_resp_rdata,
    // shared lookup and write lines to both ways
    output logic [INDEX_W-1:0]   index,
    output logic [TAG_W-1:0]     lookup_tag,
    output logic                 wr_en0,
    output logic                 wr_en1,
    output logic [TAG_W-1:0]     wr_tag,
    output dcache_pkg::line_t    wr_line,
    output logic                 wr_dirty,
    // way results
    input  logic                 hit0,
    input  logic                 hit1,
    input  logic                 valid0,
    input  logic                 valid1,
    input  logic                 dirty0,
    input  logic                 dirty1,
    input  logic [TAG_W-1:0]     tag0,
    input  logic [TAG_W-1:0]     tag1,
    input  dcache_pkg::line_t    line0,
    input  dcache_pkg::line_t    line1
);
    import dcache_pkg::*;

    localparam int SETS = 2 ** INDEX_W;

    function automatic word_t word_of(line_t line, logic [OFFSET_W-1:0] off);
        return line[off*WORD_W +: WORD_W];
    endfunction

    // replace one word of a line
    function automatic line_t merge_word(line_t line, logic [OFFSET_W-1:0] off, word_t w);
        line_t merged;
        merged = line;
        for (int i = 0; i < WORDS_PER_LINE; i++) begin
            if (i == int'(off)) begin
                merged[i*WORD_W +: WORD_W] = w;
            end
        end
        return merged;
    endfunction

    ctrl_state_t          state_q;
    ctrl_state_t          state_d;
    logic [ADDR_W-1:0]    addr_q;           // latched request
    logic                 write_q;
    word_t                wdata_q;
    logic [SETS-1:0]      lru_q;            // names the way to replace next
    logic [OFFSET_W-1:0]  offset;
    logic                 hit;
    logic                 hit_way;
    logic                 victim;
    logic                 victim_dirty;
    logic [TAG_W-1:0]     victim_tag;
    line_t                victim_line;
    line_t                base_line;
    logic                 lookup_wr;
    logic                 refill_wr;

    assign index      = addr_q[OFFSET_W +: INDEX_W];
    assign lookup_tag = addr_q[ADDR_W-1 -: TAG_W];
    assign offset     = addr_q[OFFSET_W-1:0];

    assign hit     = hit0 | hit1;
    assign hit_way = hit1 & ~hit0;          // 0 = way0, 1 = way1

    // invalid way first, LRU bit only when both are valid
    always_comb begin
        if (!valid0) begin
            victim = 1'b0;
        end else if (!valid1) begin
            victim = 1'b1;
        end else begin
            victim = lru_q[index];
        end
    end

    assign victim_dirty = victim ? (valid1 & dirty1) : (valid0 & dirty0);
    assign victim_tag   = victim ? tag1 : tag0;
    assign victim_line  = victim ? line1 : line0;

    // line the word is taken from or merged into
    assign base_line = (state_q == REFILL) ? mem_resp_rdata : (hit_way ? line1 : line0);

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (req_valid) begin
                    state_d = LOOKUP;
                end
            end
            LOOKUP: begin
                if (hit) begin
                    state_d = IDLE;
                end else if (victim_dirty) begin
                    state_d = EVICT;
                end else begin
                    state_d = FETCH;
                end
            end
            EVICT: begin
                if (mem_req_ready) begin
                    state_d = FETCH;
                end
            end
            FETCH: begin
                if (mem_req_ready) begin
                    state_d = REFILL;
                end
            end
            REFILL: begin
                if (mem_resp_valid) begin
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    // cpu side
    assign req_ready  = (state_q == IDLE);
    assign resp_valid = ((state_q == LOOKUP) && hit) || refill_wr;
    assign resp_rdata = word_of(base_line, offset);

    // memory side, fields hold while the state waits for ready
    assign mem_req_valid = (state_q == EVICT) || (state_q == FETCH);
    assign mem_req_write = (state_q == EVICT);
    assign mem_req_addr  = (state_q == EVICT) ? {victim_tag, index}
                                              : addr_q[ADDR_W-1:OFFSET_W];
    assign mem_req_wdata = victim_line;

    // way writes: write hit in LOOKUP or refill on the response
    assign lookup_wr = (state_q == LOOKUP) && hit && write_q;
    assign refill_wr = (state_q == REFILL) && mem_resp_valid;

    assign wr_en0   = (lookup_wr & ~hit_way) | (refill_wr & ~victim);
    assign wr_en1   = (lookup_wr & hit_way) | (refill_wr & victim);
    assign wr_tag   = lookup_tag;
    assign wr_line  = write_q ? merge_word(base_line, offset, wdata_q) : base_line;
    assign wr_dirty = write_q;                // reads refill clean

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= IDLE;
            lru_q   <= '0;
        end else begin
            state_q <= state_d;
            if ((state_q == LOOKUP) && hit) begin
                lru_q[index] <= ~hit_way;     // point at the other way
            end else if (refill_wr) begin
                lru_q[index] <= ~victim;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid && req_ready) begin
            addr_q  <= req_addr;
            write_q <= req_write;
            wdata_q <= req_wdata;
        end
    end

endmodule

// File: hw/dcache_top.sv
// ======================================================================
// two-way write-back, write-allocate data cache
// INDEX_W sets the number of sets, valid range 1 to 10
// cpu and memory requests use valid/ready, cpu response has no ready
// ======================================================================

`timescale 1ns/10ps

module dcache_top #(
    parameter int INDEX_W = 8,
    localparam int TAG_W = dcache_pkg::ADDR_W - INDEX_W - dcache_pkg::OFFSET_W
) (
    input  logic                 clk,
    input  logic                 reset,
    // cpu request
    input  logic                 req_valid,
    input  logic                 req_write,
    input  logic [dcache_pkg::ADDR_W-1:0] req_addr,      // word address
    input  dcache_pkg::word_t    req_wdata,
    output logic                 req_ready,
    // cpu response
    output logic                 resp_valid,             // one pulse per request
    output dcache_pkg::word_t    resp_rdata,
    // memory request
    output logic                 mem_req_valid,
    output logic                 mem_req_write,
    output logic [dcache_pkg::ADDR_W-dcache_pkg::OFFSET_W-1:0] mem_req_addr,  // line address
    output dcache_pkg::line_t    mem_req_wdata,
    input  logic                 mem_req_ready,
    // memory response
    input  logic                 mem_resp_valid,
    input  dcache_pkg::line_t    mem_resp_rdata
);
    import dcache_pkg::*;

    logic [INDEX_W-1:0] index;
    logic [TAG_W-1:0]   lookup_tag;
    logic               wr_en0;
    logic               wr_en1;
    logic [TAG_W-1:0]   wr_tag;
    line_t              wr_line;
    logic               wr_dirty;
    logic               hit0;
    logic               hit1;
    logic               valid0;
    logic               valid1;
    logic               dirty0;
    logic               dirty1;
    logic [TAG_W-1:0]   tag0;
    logic [TAG_W-1:0]   tag1;
    line_t              line0;
    line_t              line1;

    dcache_way #(.INDEX_W(INDEX_W)) way0 (
        .clk         (clk),
        .reset       (reset),
        .index       (index),
        .lookup_tag  (lookup_tag),
        .hit         (hit0),
        .valid       (valid0),
        .dirty       (dirty0),
        .stored_tag  (tag0),
        .stored_line (line0),
        .wr_en       (wr_en0),
        .wr_tag      (wr_tag),
        .wr_line     (wr_line),
        .wr_dirty    (wr_dirty)
    );

    dcache_way #(.INDEX_W(INDEX_W)) way1 (
        .clk         (clk),
        .reset       (reset),
        .index       (index),
        .lookup_tag  (lookup_tag),
        .hit         (hit1),
        .valid       (valid1),
        .dirty       (dirty1),
        .stored_tag  (tag1),
        .stored_line (line1),
        .wr_en       (wr_en1),
        .wr_tag      (wr_tag),
        .wr_line     (wr_line),
        .wr_dirty    (wr_dirty)
    );

    dcache_ctrl #(.INDEX_W(INDEX_W)) ctrl (
        .clk            (clk),
        .reset          (reset),
        .req_valid      (req_valid),
        .req_write      (req_write),
        .req_addr       (req_addr),
        .req_wdata      (req_wdata),
        .req_ready      (req_ready),
        .resp_valid     (resp_valid),
        .resp_rdata     (resp_rdata),
        .mem_req_valid  (mem_req_valid),
        .mem_req_write  (mem_req_write),
        .mem_req_addr   (mem_req_addr),
        .mem_req_wdata  (mem_req_wdata),
        .mem_req_ready  (mem_req_ready),
        .mem_resp_valid (mem_resp_valid),
        .mem_resp_rdata (mem_resp_rdata),
        .index          (index),
        .lookup_tag     (lookup_tag),
        .wr_en0         (wr_en0),
        .wr_en1         (wr_en1),
        .wr_tag         (wr_tag),
        .wr_line        (wr_line),
        .wr_dirty       (wr_dirty),
        .hit0           (hit0),
        .hit1           (hit1),
        .valid0         (valid0),
        .valid1         (valid1),
        .dirty0         (dirty0),
        .dirty1         (dirty1),
        .tag0           (tag0),
        .tag1           (tag1),
        .line0          (line0),
        .line1          (line1)
    );

endmodule

// File: testbench/next_level_model.sv
// ======================================================================
// behavioral next-level memory with whole-line reads and writes
// unwritten words read as their word address xor FILL
// ready drops for 1 to 4 cycles after every accepted request
// ======================================================================

`timescale 1ns/10ps

module next_level_model #(
    parameter logic [31:0] FILL = 32'h5a5a_0000
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 mem_req_valid,
    input  logic                 mem_req_write,
    input  logic [dcache_pkg::ADDR_W-dcache_pkg::OFFSET_W-1:0] mem_req_addr,
    input  dcache_pkg::line_t    mem_req_wdata,
    output logic                 mem_req_ready,
    output logic                 mem_resp_valid,
    output dcache_pkg::line_t    mem_resp_rdata,
    output int                   read_count,
    output int                   write_count
);
    import dcache_pkg::*;

    line_t      lines [int];                 // only lines written back
    logic [1:0] wait_cnt;
    logic [1:0] delay_sel;                   // next stall length

    function automatic line_t read_line(int line_addr);
        line_t l;
        if (lines.exists(line_addr)) begin
            return lines[line_addr];
        end
        for (int w = 0; w < WORDS_PER_LINE; w++) begin
            l[w*WORD_W +: WORD_W] = word_t'((line_addr << OFFSET_W) + w) ^ FILL;
        end
        return l;
    endfunction

    initial begin
        mem_req_ready  = 1'b0;
        mem_resp_valid = 1'b0;
        mem_resp_rdata = '0;
    end

    always @(posedge clk) begin
        if (reset) begin
            mem_req_ready  <= 1'b0;
            mem_resp_valid <= 1'b0;
            wait_cnt       <= 2'd1;
            delay_sel      <= 2'd0;
            read_count     <= 0;
            write_count    <= 0;
        end else begin
            mem_resp_valid <= 1'b0;
            if (mem_req_valid && mem_req_ready) begin
                mem_req_ready <= 1'b0;
                wait_cnt      <= delay_sel;
                delay_sel     <= delay_sel + 2'd1;
                if (mem_req_write) begin
                    lines[int'(mem_req_addr)] = mem_req_wdata;
                    write_count <= write_count + 1;
                end else begin
                    mem_resp_valid <= 1'b1;  // answer one cycle after acceptance
                    mem_resp_rdata <= read_line(int'(mem_req_addr));
                    read_count     <= read_count + 1;
                end
            end else if (wait_cnt != 2'd0) begin
                wait_cnt <= wait_cnt - 2'd1;
            end else begin
                mem_req_ready <= 1'b1;
            end
        end
    end

endmodule

// File: testbench/dcache_assert.sv
// ======================================================================
// handshake properties on the cache ports
// req_ready is high only in IDLE, so it stands for the idle state
// ======================================================================

`timescale 1ns/10ps

module dcache_assert (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 req_valid,
    input  logic                 req_ready,
    input  logic                 resp_valid,
    input  logic                 mem_req_valid,
    input  logic                 mem_req_ready,
    input  logic                 mem_req_write,
    input  logic [dcache_pkg::ADDR_W-dcache_pkg::OFFSET_W-1:0] mem_req_addr,
    input  dcache_pkg::line_t    mem_req_wdata
);
    int   fails = 0;                         // failed assertions so far
    logic busy;                              // accepted, response pending

    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= 1'b0;
        end else if (req_valid && req_ready) begin
            busy <= 1'b1;
        end else if (resp_valid) begin
            busy <= 1'b0;
        end
    end

    // memory request held with stable fields until taken
    mem_req_hold: assert property (@(posedge clk) disable iff (reset)
        mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req_write)
            && $stable(mem_req_addr) && $stable(mem_req_wdata))
        else begin
            $error("memory request dropped or changed before ready");
            fails++;
        end

    resp_not_idle: assert property (@(posedge clk) disable iff (reset)
        resp_valid |-> !req_ready)
        else begin
            $error("cpu response while the controller is idle");
            fails++;
        end

    // one request in flight
    busy_until_resp: assert property (@(posedge clk) disable iff (reset)
        busy |-> !req_ready)
        else begin
            $error("req_ready rose before the response");
            fails++;
        end

endmodule

bind dcache_top dcache_assert i_assert (.*);

// File: testbench/dcache_tb.sv
// ======================================================================
// directed and random tests of the two-way data cache with 256 sets
// inputs change on the rising edge and outputs are sampled on the falling edge
// ======================================================================

`timescale 1ns/10ps

module dcache_tb;
    import dcache_pkg::*;

    localparam int INDEX_W = 8;
    localparam logic [31:0] FILL = 32'h5a5a_0000;
    localparam logic [31:0] SEED = 32'h01d6_3662;
    localparam int TIMEOUT = 100;            // cycles allowed per wait

    logic                       clk;
    logic                       reset;
    logic                       req_valid;
    logic                       req_write;
    logic [ADDR_W-1:0]          req_addr;
    word_t                      req_wdata;
    logic                       req_ready;
    logic                       resp_valid;
    word_t                      resp_rdata;
    logic                       mem_req_valid;
    logic                       mem_req_write;
    logic [ADDR_W-OFFSET_W-1:0] mem_req_addr;
    line_t                      mem_req_wdata;
    logic                       mem_req_ready;
    logic                       mem_resp_valid;
    line_t                      mem_resp_rdata;
    int                         read_count;
    int                         write_count;

    int          errors;
    int          checks;
    int          test_errors;
    word_t       rdata;                      // last response word
    int          lat;                        // cycles from acceptance to response
    logic [31:0] rng;
    word_t       ref_mem [int];

    dcache_top #(.INDEX_W(INDEX_W)) i_dcache_top (.*);
    next_level_model #(.FILL(FILL)) i_mem (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    function automatic logic [31:0] xorshift(logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic word_t pattern(logic [ADDR_W-1:0] a);
        return word_t'(a) ^ FILL;
    endfunction

    function automatic logic [ADDR_W-1:0] waddr(int tag, int idx, int off);
        return ADDR_W'((tag << (INDEX_W + OFFSET_W)) | (idx << OFFSET_W) | off);
    endfunction

    task automatic stop_on_timeout(string what);
        $display("TIMEOUT waiting for %s", what);
        $display("Checks failed");
        $finish;
    endtask

    task automatic compare_value(string name, logic [31:0] got, logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            test_errors++;
            $display("MISMATCH %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic expect_true(logic cond, string what);
        checks++;
        assert (cond) else begin
            test_errors++;
            $display("ERROR %s", what);
        end
    endtask

    // one cpu request that leaves rdata and lat set
    task automatic access(logic wr, logic [ADDR_W-1:0] addr, word_t wdata);
        int waited;
        @(posedge clk);
        req_valid <= 1'b1;
        req_write <= wr;
        req_addr  <= addr;
        req_wdata <= wdata;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
            if (waited > TIMEOUT) begin
                stop_on_timeout("req_ready");
            end
        end while (!req_ready);
        @(posedge clk);                      // accepted at this edge
        req_valid <= 1'b0;
        lat = 0;
        do begin
            @(negedge clk);
            lat++;
            if (lat > TIMEOUT) begin
                stop_on_timeout("resp_valid");
            end
        end while (!resp_valid);
        rdata = resp_rdata;
    endtask

    task automatic read_check(logic [ADDR_W-1:0] addr, word_t exp);
        access(1'b0, addr, '0);
        compare_value("resp_rdata", rdata, exp);
    endtask

    task automatic read_fill(logic [ADDR_W-1:0] addr);
        read_check(addr, pattern(addr));
    endtask

    task automatic end_test(string name);
        $display("%-18s %0d errors", name, test_errors);
        errors += test_errors;
        test_errors = 0;
    endtask

    task automatic miss_then_hit();
        int r0;
        int w0;
        @(negedge clk);
        expect_true(req_ready && !resp_valid && !mem_req_valid, "outputs wrong after reset");
        r0 = read_count;
        w0 = write_count;
        read_fill(waddr(1, 3, 1));
        compare_value("read_count", read_count, r0 + 1);
        read_fill(waddr(1, 3, 2));
        expect_true(lat == 1, "read hit did not answer one cycle after acceptance");
        compare_value("read_count", read_count, r0 + 1);
        compare_value("write_count", write_count, w0);
        end_test("miss_then_hit");
    endtask

    task automatic write_hit_readback();
        access(1'b1, waddr(1, 3, 0), 32'hcafe_0001);
        expect_true(lat == 1, "write hit did not answer one cycle after acceptance");
        read_check(waddr(1, 3, 0), 32'hcafe_0001);
        for (int w = 1; w < WORDS_PER_LINE; w++) begin
            read_fill(waddr(1, 3, w));
        end
        end_test("write_hit");
    endtask

    task automatic dirty_eviction();
        int w0;
        access(1'b1, waddr(5, 10, 2), 32'hdead_beef);
        w0 = write_count;
        read_fill(waddr(6, 10, 0));          // fills the second way
        read_fill(waddr(7, 10, 0));          // pushes out the dirty line
        compare_value("write_count", write_count, w0 + 1);
        read_check(waddr(5, 10, 2), 32'hdead_beef);
        end_test("dirty_evict");
    endtask

    task automatic lru_victim_choice();
        int r0;
        read_fill(waddr(8, 20, 0));
        read_fill(waddr(9, 20, 0));
        read_fill(waddr(8, 20, 1));
        read_fill(waddr(10, 20, 0));         // B is least recent
        r0 = read_count;
        read_fill(waddr(8, 20, 2));
        compare_value("read_count", read_count, r0);
        read_fill(waddr(9, 20, 2));
        compare_value("read_count", read_count, r0 + 1);
        end_test("lru_victim");
    endtask

    task automatic write_miss_allocate();
        int r0;
        r0 = read_count;
        access(1'b1, waddr(11, 30, 1), 32'h1234_5678);
        compare_value("read_count", read_count, r0 + 1);
        read_check(waddr(11, 30, 1), 32'h1234_5678);
        read_fill(waddr(11, 30, 2));
        end_test("write_allocate");
    endtask

    // four tags over two sets keep lines evicting each other
    task automatic random_traffic();
        logic [ADDR_W-1:0] a;
        word_t             exp;
        rng = SEED;
        for (int n = 0; n < 200; n++) begin
            rng = xorshift(rng);
            a = waddr(100 + rng[1:0], 40 + rng[2], rng[4:3]);
            if (rng[5]) begin
                rng = xorshift(rng);
                access(1'b1, a, rng);
                ref_mem[int'(a)] = rng;
            end else begin
                exp = ref_mem.exists(int'(a)) ? ref_mem[int'(a)] : pattern(a);
                read_check(a, exp);
            end
        end
        end_test("random_traffic");
    endtask

    initial begin
        reset       = 1'b1;
        req_valid   = 1'b0;
        req_write   = 1'b0;
        req_addr    = '0;
        req_wdata   = '0;
        errors      = 0;
        checks      = 0;
        test_errors = 0;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        miss_then_hit();
        write_hit_readback();
        dirty_eviction();
        lru_victim_choice();
        write_miss_allocate();
        random_traffic();
        errors += i_dcache_top.i_assert.fails;
        $display("%0d checks, %0d errors, %0d assertion failures",
                 checks, errors, i_dcache_top.i_assert.fails);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: compile.f
hw/dcache_pkg.sv
hw/dcache_way.sv
hw/dcache_ctrl.sv
hw/dcache_top.sv
testbench/next_level_model.sv
testbench/dcache_assert.sv
testbench/dcache_tb.sv
